//--- hw/graph_pkg.sv
package graph_pkg;

   localparam int addr_w = 32;

   // header burst, only the vertex base is kept
   localparam logic [7:0] header_len = 8'd14;
   localparam logic [3:0] header_base_word = 4'd5;

   // vertex record layout, 64 bytes each
   localparam int vertex_shift = 6;
   localparam logic [addr_w-1:0] excess_off = 32'd0;
   localparam logic [addr_w-1:0] active_off = 32'd4;
   localparam logic [addr_w-1:0] height_off = 32'd16;
   localparam logic [addr_w-1:0] flow_slot_base = 32'd6; // in words
   localparam int flow_slot_w = 4;

   typedef enum logic [1:0] {
      rd_header,
      rd_height,
      rd_excess_active,
      rd_flow
   } rd_target_t;

   typedef enum logic [1:0] {
      wr_flow,
      wr_excess,
      wr_active
   } wr_target_t;

endpackage

//--- hw/task_pkg.sv
package task_pkg;

   localparam int ts_w = 32;
   localparam int hint_w = 32;
   localparam int ttype_w = 4;
   localparam int args_w = 64;
   localparam int task_w = args_w + ttype_w + hint_w + ts_w;

   typedef enum logic [ttype_w-1:0] {
      tt_discharge = 4'd0,
      tt_get_height = 4'd1,
      tt_push = 4'd2,
      tt_receive = 4'd3,
      tt_bfs = 4'd4
   } task_type_t;

   typedef struct packed {
      logic [args_w-1:0] args;
      task_type_t ttype;
      logic [hint_w-1:0] hint;
      logic [ts_w-1:0] ts;
   } task_t;

   // successor built by the emitter
   typedef enum logic {
      enq_push,
      enq_discharge
   } enq_kind_t;

endpackage

//--- hw/mem_reader.sv
`timescale 1ns/10ps
module mem_reader (
   input  logic clk,
   input  logic rstn,
   input  logic rd_start,
   input  graph_pkg::rd_target_t rd_target,
   input  logic [task_pkg::hint_w-1:0] vertex,
   input  logic [graph_pkg::flow_slot_w-1:0] flow_slot,
   input  logic ar_ready,
   input  logic r_valid,
   input  logic [graph_pkg::addr_w-1:0] r_data,
   input  logic r_last,
   output logic ar_valid,
   output logic [graph_pkg::addr_w-1:0] ar_addr,
   output logic [7:0] ar_len,
   output logic rd_done,
   output logic [graph_pkg::addr_w-1:0] vertex_addr,
   output logic [graph_pkg::addr_w-1:0] height,
   output logic signed [graph_pkg::addr_w-1:0] excess,
   output logic active,
   output logic signed [graph_pkg::addr_w-1:0] flow
);
   graph_pkg::rd_target_t target;
   logic [graph_pkg::addr_w-1:0] vertex_base;
   logic [3:0] beat; // enough for the 14 header words
   logic busy;

   // top bit of the hint is a read-only marker
   assign vertex_addr = vertex_base +
                        ({1'b0, vertex[task_pkg::hint_w-2:0]} << graph_pkg::vertex_shift);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ar_valid <= 1'b0;
         busy <= 1'b0;
         beat <= '0;
         rd_done <= 1'b0;
      end else begin
         rd_done <= 1'b0;
         if (rd_start) begin
            ar_valid <= 1'b1;
            busy <= 1'b1;
            beat <= '0;
         end else begin
            if (ar_valid && ar_ready) begin
               ar_valid <= 1'b0;
            end
            if (busy && r_valid) begin
               beat <= beat + 4'd1;
               if (r_last) begin
                  busy <= 1'b0;
                  rd_done <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_start) begin
         target <= rd_target;
         case (rd_target)
            graph_pkg::rd_header: begin
               ar_addr <= '0;
               ar_len <= graph_pkg::header_len - 8'd1;
            end
            graph_pkg::rd_height: begin
               ar_addr <= vertex_addr + graph_pkg::height_off;
               ar_len <= 8'd0;
            end
            graph_pkg::rd_excess_active: begin
               ar_addr <= vertex_addr + graph_pkg::excess_off;
               ar_len <= 8'd1; // excess then active
            end
            default: begin
               ar_addr <= vertex_addr + ((graph_pkg::flow_slot_base + flow_slot) << 2);
               ar_len <= 8'd0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (busy && r_valid) begin
         case (target)
            graph_pkg::rd_header: begin
               if (beat == graph_pkg::header_base_word) begin
                  vertex_base <= {r_data[graph_pkg::addr_w-3:0], 2'b00}; // word to byte
               end
            end
            graph_pkg::rd_height: height <= r_data;
            graph_pkg::rd_excess_active: begin
               if (beat == 4'd0) begin
                  excess <= r_data;
               end else begin
                  active <= r_data[0];
               end
            end
            default: flow <= r_data;
         endcase
      end
   end

endmodule

//--- hw/task_sequencer.sv
`timescale 1ns/10ps
module task_sequencer (
   input  logic clk,
   input  logic rstn,
   input  logic start,
   input  task_pkg::task_t task_in,
   input  logic rd_done,
   input  logic wr_done,
   input  logic enq_done,
   input  logic signed [graph_pkg::addr_w-1:0] excess,
   input  logic active,
   output logic done,
   output logic idle,
   output logic ready,
   output logic rd_start,
   output graph_pkg::rd_target_t rd_target,
   output logic wr_start,
   output graph_pkg::wr_target_t wr_target,
   output logic enq_start,
   output task_pkg::enq_kind_t enq_kind,
   output logic [task_pkg::hint_w-1:0] vertex,
   output logic [graph_pkg::flow_slot_w-1:0] flow_slot,
   output logic signed [task_pkg::args_w/2-1:0] amount,
   output logic [task_pkg::args_w/2-1:0] arg_lo,
   output logic [task_pkg::ts_w-1:0] cur_ts
);
   typedef enum logic [3:0] {
      s_idle, s_header, s_dispatch,
      s_gh_read, s_gh_enq,
      s_rx_vid, s_rx_flow, s_rx_wflow, s_rx_wexcess, s_rx_wactive, s_rx_enq,
      s_finish
   } state_t;

   state_t state;
   task_pkg::task_t cur_task;
   logic initialized;
   logic issued; // strobe for this phase already sent
   logic signed [graph_pkg::addr_w-1:0] new_excess;

   assign vertex = cur_task.hint;
   assign arg_lo = cur_task.args[task_pkg::args_w/2-1:0];
   assign amount = cur_task.args[task_pkg::args_w-1:task_pkg::args_w/2];
   assign cur_ts = cur_task.ts;
   assign flow_slot = arg_lo[graph_pkg::flow_slot_w-1:0];
   assign new_excess = excess + amount;

   assign idle = (state == s_idle);
   assign ready = (state == s_idle);
   assign done = (state == s_finish);

   always_comb begin
      rd_start = 1'b0;
      wr_start = 1'b0;
      enq_start = 1'b0;
      rd_target = graph_pkg::rd_header;
      wr_target = graph_pkg::wr_flow;
      enq_kind = task_pkg::enq_push;
      case (state)
         s_header: rd_start = !issued;
         s_gh_read: begin
            rd_start = !issued;
            rd_target = graph_pkg::rd_height;
         end
         s_gh_enq: enq_start = !issued;
         s_rx_vid: begin
            rd_start = !issued;
            rd_target = graph_pkg::rd_excess_active;
         end
         s_rx_flow: begin
            rd_start = !issued;
            rd_target = graph_pkg::rd_flow;
         end
         s_rx_wflow: wr_start = !issued;
         s_rx_wexcess: begin
            wr_start = !issued;
            wr_target = graph_pkg::wr_excess;
         end
         s_rx_wactive: begin
            wr_start = !issued;
            wr_target = graph_pkg::wr_active;
         end
         s_rx_enq: begin
            enq_start = !issued;
            enq_kind = task_pkg::enq_discharge;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (idle && start) begin
         cur_task <= task_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= s_idle;
         initialized <= 1'b0;
         issued <= 1'b0;
      end else begin
         if (rd_start || wr_start || enq_start) begin
            issued <= 1'b1;
         end else if (rd_done || wr_done || enq_done) begin
            issued <= 1'b0;
         end
         case (state)
            s_idle: if (start) state <= initialized ? s_dispatch : s_header;
            s_header: begin
               if (rd_done) begin
                  initialized <= 1'b1;
                  state <= s_dispatch;
               end
            end
            s_dispatch: begin
               case (cur_task.ttype)
                  task_pkg::tt_get_height: state <= s_gh_read;
                  task_pkg::tt_receive: state <= s_rx_vid;
                  default: state <= s_finish; // dropped or unknown type
               endcase
            end
            s_gh_read: if (rd_done) state <= s_gh_enq;
            s_gh_enq: if (enq_done) state <= s_finish;
            s_rx_vid: if (rd_done) state <= s_rx_flow;
            s_rx_flow: if (rd_done) state <= s_rx_wflow;
            s_rx_wflow: if (wr_done) state <= s_rx_wexcess;
            s_rx_wexcess: begin
               if (wr_done) begin
                  state <= (new_excess > 0 && !active) ? s_rx_wactive : s_finish;
               end
            end
            s_rx_wactive: if (wr_done) state <= s_rx_enq;
            s_rx_enq: if (enq_done) state <= s_finish;
            default: state <= s_idle;
         endcase
      end
   end

endmodule

//--- hw/update_writer.sv
`timescale 1ns/10ps
module update_writer (
   input  logic clk,
   input  logic rstn,
   input  logic wr_start,
   input  graph_pkg::wr_target_t wr_target,
   input  logic [graph_pkg::addr_w-1:0] vertex_addr,
   input  logic [graph_pkg::flow_slot_w-1:0] flow_slot,
   input  logic signed [graph_pkg::addr_w-1:0] flow,
   input  logic signed [graph_pkg::addr_w-1:0] excess,
   input  logic signed [task_pkg::args_w/2-1:0] amount,
   input  logic undo_ready,
   input  logic aw_ready,
   output logic undo_valid,
   output logic [2*graph_pkg::addr_w-1:0] undo_entry,
   output logic aw_valid,
   output logic [graph_pkg::addr_w-1:0] aw_addr,
   output logic w_valid,
   output logic [graph_pkg::addr_w-1:0] w_data,
   output logic wr_done
);
   typedef enum logic [1:0] {w_idle, w_undo, w_write} wstate_t;

   wstate_t state;
   logic [graph_pkg::addr_w-1:0] addr_q, old_q, new_q;

   assign undo_valid = (state == w_undo);
   assign undo_entry = {old_q, addr_q};
   assign aw_valid = (state == w_write);
   assign w_valid = aw_valid; // single-beat write, data goes with address
   assign aw_addr = addr_q;
   assign w_data = new_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= w_idle;
         wr_done <= 1'b0;
      end else begin
         wr_done <= 1'b0;
         case (state)
            w_idle: if (wr_start) state <= w_undo;
            w_undo: if (undo_ready) state <= w_write; // log before memory
            w_write: begin
               if (aw_ready) begin
                  state <= w_idle;
                  wr_done <= 1'b1;
               end
            end
            default: state <= w_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_start) begin
         case (wr_target)
            graph_pkg::wr_flow: begin
               addr_q <= vertex_addr + ((graph_pkg::flow_slot_base + flow_slot) << 2);
               old_q <= flow;
               new_q <= flow - amount; // reverse edge direction
            end
            graph_pkg::wr_excess: begin
               addr_q <= vertex_addr + graph_pkg::excess_off;
               old_q <= excess;
               new_q <= excess + amount;
            end
            default: begin
               addr_q <= vertex_addr + graph_pkg::active_off;
               old_q <= '0;
               new_q <= 32'd1;
            end
         endcase
      end
   end

endmodule

//--- hw/task_emitter.sv
`timescale 1ns/10ps
module task_emitter (
   input  logic clk,
   input  logic rstn,
   input  logic enq_start,
   input  task_pkg::enq_kind_t enq_kind,
   input  logic [task_pkg::hint_w-1:0] vertex,
   input  logic [task_pkg::args_w/2-1:0] arg_lo,
   input  logic signed [task_pkg::args_w/2-1:0] amount,
   input  logic [task_pkg::ts_w-1:0] cur_ts,
   input  logic [graph_pkg::addr_w-1:0] height,
   input  logic task_out_ready,
   output task_pkg::task_t task_out,
   output logic task_out_valid,
   output logic enq_done
);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_out_valid <= 1'b0;
         enq_done <= 1'b0;
      end else begin
         enq_done <= 1'b0;
         if (enq_start) begin
            task_out_valid <= 1'b1;
         end else if (task_out_valid && task_out_ready) begin
            task_out_valid <= 1'b0;
            enq_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (enq_start) begin
         task_out.ts <= cur_ts;
         if (enq_kind == task_pkg::enq_push) begin
            task_out.ttype <= task_pkg::tt_push;
            task_out.hint <= arg_lo; // back to the pushing vertex
            task_out.args <= {amount, height};
         end else begin
            task_out.ttype <= task_pkg::tt_discharge;
            task_out.hint <= vertex;
            task_out.args <= {cur_ts, 32'd0};
         end
      end
   end

endmodule

//--- hw/task_unit_top.sv
`timescale 1ns/10ps
module task_unit_top (
   input  logic clk,
   input  logic rstn,
   input  logic start,
   input  logic [task_pkg::task_w-1:0] task_in,
   output logic done,
   output logic idle,
   output logic ready,
   output logic ar_valid,
   input  logic ar_ready,
   output logic [graph_pkg::addr_w-1:0] ar_addr,
   output logic [7:0] ar_len,
   input  logic r_valid,
   output logic r_ready,
   input  logic [graph_pkg::addr_w-1:0] r_data,
   input  logic r_last,
   output logic aw_valid,
   input  logic aw_ready,
   output logic [graph_pkg::addr_w-1:0] aw_addr,
   output logic w_valid,
   output logic [graph_pkg::addr_w-1:0] w_data,
   output logic [2*graph_pkg::addr_w-1:0] undo_entry,
   output logic undo_valid,
   input  logic undo_ready,
   output logic [task_pkg::task_w-1:0] task_out,
   output logic task_out_valid,
   input  logic task_out_ready
);
   logic rd_start, rd_done, wr_start, wr_done, enq_start, enq_done;
   graph_pkg::rd_target_t rd_target;
   graph_pkg::wr_target_t wr_target;
   task_pkg::enq_kind_t enq_kind;
   logic [task_pkg::hint_w-1:0] vertex;
   logic [graph_pkg::flow_slot_w-1:0] flow_slot;
   logic signed [task_pkg::args_w/2-1:0] amount;
   logic [task_pkg::args_w/2-1:0] arg_lo;
   logic [task_pkg::ts_w-1:0] cur_ts;
   logic [graph_pkg::addr_w-1:0] vertex_addr, height;
   logic signed [graph_pkg::addr_w-1:0] excess, flow;
   logic active;

   assign r_ready = 1'b1; // every beat is taken as it comes

   mem_reader reader_i (
      .clk(clk), .rstn(rstn), .rd_start(rd_start), .rd_target(rd_target),
      .vertex(vertex), .flow_slot(flow_slot), .ar_ready(ar_ready), .r_valid(r_valid),
      .r_data(r_data), .r_last(r_last), .ar_valid(ar_valid), .ar_addr(ar_addr),
      .ar_len(ar_len), .rd_done(rd_done), .vertex_addr(vertex_addr), .height(height),
      .excess(excess), .active(active), .flow(flow)
   );

   task_sequencer seq_i (
      .clk(clk), .rstn(rstn), .start(start), .task_in(task_in), .rd_done(rd_done),
      .wr_done(wr_done), .enq_done(enq_done), .excess(excess), .active(active),
      .done(done), .idle(idle), .ready(ready), .rd_start(rd_start),
      .rd_target(rd_target), .wr_start(wr_start), .wr_target(wr_target),
      .enq_start(enq_start), .enq_kind(enq_kind), .vertex(vertex),
      .flow_slot(flow_slot), .amount(amount), .arg_lo(arg_lo), .cur_ts(cur_ts)
   );

   update_writer writer_i (
      .clk(clk), .rstn(rstn), .wr_start(wr_start), .wr_target(wr_target),
      .vertex_addr(vertex_addr), .flow_slot(flow_slot), .flow(flow), .excess(excess),
      .amount(amount), .undo_ready(undo_ready), .aw_ready(aw_ready),
      .undo_valid(undo_valid), .undo_entry(undo_entry), .aw_valid(aw_valid),
      .aw_addr(aw_addr), .w_valid(w_valid), .w_data(w_data), .wr_done(wr_done)
   );

   task_emitter emitter_i (
      .clk(clk), .rstn(rstn), .enq_start(enq_start), .enq_kind(enq_kind),
      .vertex(vertex), .arg_lo(arg_lo), .amount(amount), .cur_ts(cur_ts),
      .height(height), .task_out_ready(task_out_ready), .task_out(task_out),
      .task_out_valid(task_out_valid), .enq_done(enq_done)
   );

endmodule

//--- verification/graph_memory.sv
`timescale 1ns/10ps
module graph_memory #(
   parameter logic [31:0] seed = 32'd19
) (
   input  logic clk,
   input  logic rstn,
   input  logic ar_valid,
   output logic ar_ready,
   input  logic [graph_pkg::addr_w-1:0] ar_addr,
   input  logic [7:0] ar_len,
   output logic r_valid,
   input  logic r_ready,
   output logic [graph_pkg::addr_w-1:0] r_data,
   output logic r_last,
   input  logic aw_valid,
   output logic aw_ready,
   input  logic [graph_pkg::addr_w-1:0] aw_addr,
   input  logic w_valid,
   input  logic [graph_pkg::addr_w-1:0] w_data
);
   logic [31:0] memory [0:2047]; // word index is byte address bits 12:2
   logic [31:0] rng;
   logic [31:0] rd_addr;
   logic [7:0] rd_len, rd_beat;
   logic [10:0] word_idx;
   logic reading;

   function automatic logic [31:0] lcg_step(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   initial begin
      int base;
      ar_ready = 1'b0;
      r_valid = 1'b0;
      r_data = '0;
      r_last = 1'b0;
      aw_ready = 1'b0;
      rng = seed;
      for (int i = 0; i < 2048; i++) begin
         memory[i] = lcg_step((32'(i) << 2) ^ seed); // background from the address
      end
      memory[5] = 32'h400; // vertex data base, byte 0x1000
      for (int v = 0; v < 16; v++) begin
         base = 1024 + v * 16;
         rng = lcg_step(rng);
         memory[base] = 32'(int'(rng[23:8] % 41) - 20); // excess
         rng = lcg_step(rng);
         memory[base + 1] = {31'd0, rng[20]}; // active flag
         rng = lcg_step(rng);
         memory[base + 4] = 32'(rng[23:8] % 64); // height
         for (int s = 0; s < 10; s++) begin
            rng = lcg_step(rng);
            memory[base + 6 + s] = 32'(int'(rng[23:8] % 101) - 50);
         end
      end
   end

   always @(posedge clk) begin
      if (!rstn) begin
         reading <= 1'b0;
         rd_addr <= '0;
         rd_len <= '0;
         rd_beat <= '0;
      end else begin
         if (ar_valid && ar_ready) begin
            reading <= 1'b1;
            rd_addr <= ar_addr;
            rd_len <= ar_len;
            rd_beat <= '0;
         end else if (r_valid && r_ready) begin
            rd_beat <= rd_beat + 8'd1;
            if (r_last) reading <= 1'b0;
         end
         if (aw_valid && w_valid && aw_ready) memory[aw_addr[12:2]] <= w_data;
      end
   end

   // stalls and read beats change on the falling edge
   always @(negedge clk) begin
      rng = lcg_step(rng);
      word_idx = rd_addr[12:2] + 11'(rd_beat);
      ar_ready = rstn && !reading && rng[16];
      r_valid = rstn && reading && (rng[18:17] != 2'b00);
      r_data = memory[word_idx];
      r_last = (rd_beat == rd_len);
      aw_ready = rstn && (rng[20:19] != 2'b00);
   end

endmodule

//--- verification/task_unit_tb.sv
`timescale 1ns/10ps
module task_unit_tb;
   localparam logic [31:0] seed = 32'd19;
   localparam int rand_tasks = 40;
   localparam int num_tasks = rand_tasks + 7;

   logic clk, rstn, start;
   logic [task_pkg::task_w-1:0] task_in, task_out;
   logic done, idle, ready;
   logic ar_valid, ar_ready, r_valid, r_ready, r_last;
   logic [7:0] ar_len;
   logic [31:0] ar_addr, r_data, aw_addr, w_data;
   logic aw_valid, aw_ready, w_valid;
   logic [63:0] undo_entry;
   logic undo_valid, undo_ready, task_out_valid, task_out_ready;

   logic [31:0] exp_mem [0:2047];
   logic [31:0] rand_state, stall_state;
   logic [131:0] got_ar[$], got_undo[$], got_wr[$], got_out[$];
   logic [131:0] exp_ar[$], exp_undo[$], exp_wr[$], exp_out[$];
   int hs_errors, data_errors, header_reads;
   logic init_done;

   task_unit_top dut_i (
      .clk(clk), .rstn(rstn), .start(start), .task_in(task_in), .done(done),
      .idle(idle), .ready(ready), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .ar_addr(ar_addr), .ar_len(ar_len), .r_valid(r_valid), .r_ready(r_ready),
      .r_data(r_data), .r_last(r_last), .aw_valid(aw_valid), .aw_ready(aw_ready),
      .aw_addr(aw_addr), .w_valid(w_valid), .w_data(w_data), .undo_entry(undo_entry),
      .undo_valid(undo_valid), .undo_ready(undo_ready), .task_out(task_out),
      .task_out_valid(task_out_valid), .task_out_ready(task_out_ready)
   );

   graph_memory #(.seed(seed)) mem_i (
      .clk(clk), .rstn(rstn), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .ar_addr(ar_addr), .ar_len(ar_len), .r_valid(r_valid), .r_ready(r_ready),
      .r_data(r_data), .r_last(r_last), .aw_valid(aw_valid), .aw_ready(aw_ready),
      .aw_addr(aw_addr), .w_valid(w_valid), .w_data(w_data)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rnd();
      rand_state = lcg_step(rand_state);
      return rand_state >> 8;
   endfunction

   task automatic flag_handshake(input string msg);
      hs_errors++;
      $display("Error %0t: %s", $time, msg);
   endtask

   always @(negedge clk) begin
      stall_state = lcg_step(stall_state);
      undo_ready = stall_state[20] | stall_state[21];
      task_out_ready = stall_state[22];
   end

   // record every completed transfer
   always @(posedge clk) begin
      if (rstn) begin
         if (ar_valid && ar_ready) begin
            got_ar.push_back({ar_len, ar_addr});
            if (ar_addr == 32'd0 && ar_len == 8'd13) header_reads++;
         end
         if (undo_valid && undo_ready) got_undo.push_back(undo_entry);
         if (aw_valid && aw_ready) got_wr.push_back({aw_addr, w_data});
         if (task_out_valid && task_out_ready) got_out.push_back(task_out);
      end
   end

   ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
      else flag_handshake("read request dropped or changed while stalled");
   undo_hold: assert property (@(posedge clk) disable iff (!rstn)
      undo_valid && !undo_ready |=> undo_valid && $stable(undo_entry))
      else flag_handshake("undo entry dropped or changed while stalled");
   aw_hold: assert property (@(posedge clk) disable iff (!rstn)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(w_data))
      else flag_handshake("write dropped or changed while stalled");
   out_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out))
      else flag_handshake("output task dropped or changed while stalled");
   w_with_aw: assert property (@(posedge clk) disable iff (!rstn) aw_valid == w_valid)
      else flag_handshake("w_valid differs from aw_valid");
   r_ready_high: assert property (@(posedge clk) disable iff (!rstn) r_ready)
      else flag_handshake("r_ready was not held high");
   one_busy: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0({ar_valid, undo_valid, aw_valid, task_out_valid}))
      else flag_handshake("more than one channel active at once");
   idle_after_done: assert property (@(posedge clk) disable iff (!rstn) done |=> idle)
      else flag_handshake("idle did not return after done");
   header_once: assert property (@(posedge clk) disable iff (!rstn)
      ar_valid && ar_ready && ar_addr == 32'd0 && ar_len == 8'd13 |-> header_reads == 0)
      else flag_handshake("header burst issued a second time");

   task automatic check_list(input string name, input logic [131:0] got[$],
                             input logic [131:0] want[$]);
      assert (got.size() == want.size()) else begin
         data_errors++;
         $display("Error %0t: %s saw %0d transfers, expected %0d", $time, name,
                  got.size(), want.size());
      end
      if (got.size() == want.size()) begin
         foreach (want[i]) begin
            assert (got[i] === want[i]) else begin
               data_errors++;
               $display("Error %0t: %s transfer %0d is %h, expected %h", $time, name, i,
                        got[i], want[i]);
            end
         end
      end
   endtask

   task automatic run_task(input logic [3:0] ttype, input logic [31:0] hint,
                           input logic [63:0] args, input logic [31:0] ts);
      logic [31:0] vbase, va, ea, aa, fa;
      logic signed [31:0] amount, old_ex, old_fl, sum;
      int cycles;
      got_ar.delete();
      got_undo.delete();
      got_wr.delete();
      got_out.delete();
      exp_ar.delete();
      exp_undo.delete();
      exp_wr.delete();
      exp_out.delete();
      vbase = (exp_mem[5] & 32'h7fff_ffff) << 2;
      va = vbase + ({1'b0, hint[30:0]} << 6); // top hint bit is not part of the index
      if (!init_done) exp_ar.push_back({8'd13, 32'd0});
      if (ttype == 4'd1) begin
         exp_ar.push_back({8'd0, va + 32'd16});
         exp_out.push_back({args[63:32], exp_mem[(va + 32'd16) >> 2], 4'd2, args[31:0], ts});
      end else if (ttype == 4'd3) begin
         amount = args[63:32];
         ea = va;
         aa = va + 32'd4;
         fa = va + ((32'd6 + args[3:0]) << 2);
         old_ex = exp_mem[ea >> 2];
         old_fl = exp_mem[fa >> 2];
         sum = old_ex + amount;
         exp_ar.push_back({8'd1, ea});
         exp_ar.push_back({8'd0, fa});
         exp_undo.push_back({old_fl, fa});
         exp_wr.push_back({fa, old_fl - amount});
         exp_undo.push_back({old_ex, ea});
         exp_wr.push_back({ea, sum});
         if (sum > 0 && !exp_mem[aa >> 2][0]) begin
            exp_undo.push_back({32'd0, aa});
            exp_wr.push_back({aa, 32'd1});
            exp_out.push_back({ts, 32'd0, 4'd0, hint, ts});
            exp_mem[aa >> 2] = 32'd1;
         end
         exp_mem[fa >> 2] = old_fl - amount;
         exp_mem[ea >> 2] = sum;
      end
      while (!idle) @(negedge clk);
      task_in = {args, ttype, hint, ts};
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      cycles = 1;
      assert (!idle) else begin
         data_errors++;
         $display("Error %0t: idle still high one cycle after start", $time);
      end
      while (!done) begin
         @(negedge clk);
         cycles++;
      end
      if (init_done && ttype != 4'd1 && ttype != 4'd3) begin
         assert (cycles == 2) else begin
            data_errors++;
            $display("Error %0t: type %0d reached done after %0d cycles, expected 2", $time,
                     ttype, cycles);
         end
      end
      @(negedge clk);
      init_done = 1'b1;
      check_list("read", got_ar, exp_ar);
      check_list("undo", got_undo, exp_undo);
      check_list("write", got_wr, exp_wr);
      check_list("task out", got_out, exp_out);
   endtask

   initial begin
      int act_v;
      logic [31:0] vbase, hint, ts;
      logic [63:0] args;
      logic [3:0] ttype;
      logic [2:0] sel;
      clk = 1'b0;
      rstn = 1'b0;
      start = 1'b0;
      task_in = '0;
      undo_ready = 1'b0;
      task_out_ready = 1'b0;
      rand_state = seed;
      stall_state = seed;
      hs_errors = 0;
      data_errors = 0;
      header_reads = 0;
      init_done = 1'b0;
      repeat (5) @(negedge clk);
      assert (idle && ready && !done && !ar_valid && !aw_valid && !w_valid && !undo_valid
              && !task_out_valid) else begin
         data_errors++;
         $display("Error %0t: outputs not at their reset values", $time);
      end
      for (int i = 0; i < 2048; i++) exp_mem[i] = mem_i.memory[i];
      rstn = 1'b1;
      @(negedge clk);

      run_task(4'd1, 32'd2, {32'h0000_0055, 32'd7}, 32'd100); // also loads the header
      for (int k = 0; k < 4; k++) begin
         run_task((k == 3) ? 4'd7 : 4'(2 * k), 32'd3, {32'd5, 32'd1}, 32'd200 + k);
      end

      vbase = (exp_mem[5] & 32'h7fff_ffff) << 2;
      act_v = -1;
      for (int v = 15; v >= 0; v--) begin
         if (!exp_mem[(vbase + 32'(v) * 64 + 32'd4) >> 2][0]) act_v = v;
      end
      if (act_v >= 0) run_task(4'd3, 32'(act_v), {32'd40, 32'd2}, 32'd300);
      run_task(4'd3, 32'd1, {-32'sd60, 32'd4}, 32'd301); // excess stays negative

      for (int n = 0; n < rand_tasks; n++) begin
         sel = rnd() % 8;
         hint = rnd() % 16;
         if (rnd() % 8 == 0) hint[31] = 1'b1;
         ts = rnd();
         args[63:32] = 32'(int'(rnd() % 61) - 30);
         args[31:0] = (rnd() & 32'hffff_fff0) | (rnd() % 10);
         if (sel < 3'd3) ttype = 4'd1;
         else if (sel < 3'd6) ttype = 4'd3;
         else ttype = (sel == 3'd6) ? 4'(2 * (rnd() % 3)) : 4'd7;
         run_task(ttype, hint, args, ts);
      end

      assert (header_reads == 1) else begin
         data_errors++;
         $display("Error %0t: saw %0d header bursts, expected 1", $time, header_reads);
      end
      $display("errors: %0d handshake, %0d data", hs_errors, data_errors);
      if (hs_errors == 0 && data_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(num_tasks * 400 * 4);
      $display("timeout: the tasks did not all finish in the allowed time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- build.f
hw/graph_pkg.sv
hw/task_pkg.sv
hw/mem_reader.sv
hw/task_sequencer.sv
hw/update_writer.sv
hw/task_emitter.sv
hw/task_unit_top.sv
verification/graph_memory.sv
verification/task_unit_tb.sv
